// File: hw/cpu_io_pkg.sv
`default_nettype none

package cpu_io_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int byte_w     = 8;

    // ==============================
    // serial timing
    // ==============================
    localparam int clks_per_bit = 16;

    // baud counter and bit counter ranges
    localparam int baud_w    = $clog2(clks_per_bit);
    localparam int bit_cnt_w = $clog2(byte_w);
    localparam logic [baud_w-1:0]    baud_last = baud_w'(clks_per_bit - 1);
    localparam logic [baud_w-1:0]    baud_half = baud_w'(clks_per_bit / 2 - 1);
    localparam logic [bit_cnt_w-1:0] bit_last  = bit_cnt_w'(byte_w - 1);

    // ==============================
    // encodings
    // ==============================
    typedef enum logic [2:0] {
        op_nop,
        op_li,
        op_inll,
        op_outll
    } op_t;

    typedef enum logic [2:0] {
        run_st,
        pre_read_st,
        read_st,
        pre_write_st,
        write_st
    } io_state_t;

    // shared by both uart engines
    typedef enum logic [1:0] {
        idle_st,
        start_st,
        data_st,
        stop_st
    } uart_state_t;

endpackage

`default_nettype wire

// File: hw/io_if.sv
`default_nettype none

// sequencer to transmitter
interface uart_tx_if;
    logic                          wen;
    logic [cpu_io_pkg::byte_w-1:0] wdata;
    logic                          wbusy;
    logic                          wdone;

    modport seq (
        output wen,
        output wdata,
        input  wbusy,
        input  wdone
    );

    modport tx (
        input  wen,
        input  wdata,
        output wbusy,
        output wdone
    );
endinterface

// receiver to sequencer
interface uart_rx_if;
    logic                          ren;
    logic [cpu_io_pkg::byte_w-1:0] rdata;
    logic                          rbusy;
    logic                          rdone;

    modport seq (
        output ren,
        input  rdata,
        input  rbusy,
        input  rdone
    );

    modport rx (
        input  ren,
        output rdata,
        output rbusy,
        output rdone
    );
endinterface

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic                              we,
    input  wire logic [cpu_io_pkg::reg_addr_w-1:0] waddr,
    input  wire logic [cpu_io_pkg::xlen-1:0]       wdata,
    input  wire logic [cpu_io_pkg::reg_addr_w-1:0] raddr,
    output logic      [cpu_io_pkg::xlen-1:0]       rdata,
    output logic      [cpu_io_pkg::byte_w-1:0]     led
);

    logic [cpu_io_pkg::xlen-1:0] gpr [cpu_io_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < cpu_io_pkg::num_regs; i++) begin
                gpr[i] <= '0;
            end
        end else if (we) begin
            gpr[waddr] <= wdata;
        end
    end

    assign rdata = gpr[raddr];

    // led tap on r0
    assign led = gpr[0][cpu_io_pkg::byte_w-1:0];

    // write address from the sequencer must be resolved
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rstn)
        we |-> !$isunknown(waddr)
    );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire logic clk,
    input  wire logic rstn,
    uart_tx_if.tx     io,
    output logic      tx
);

    cpu_io_pkg::uart_state_t               state;
    logic [cpu_io_pkg::baud_w-1:0]         baud_cnt;
    logic [cpu_io_pkg::bit_cnt_w-1:0]      bit_cnt;
    logic [cpu_io_pkg::byte_w-1:0]         shift;
    logic                                  bit_end;

    assign bit_end = (baud_cnt == cpu_io_pkg::baud_last);

    // shift register holds payload only
    always_ff @(posedge clk) begin
        if (state == cpu_io_pkg::idle_st && io.wen) begin
            shift <= io.wdata;
        end else if (bit_end && state != cpu_io_pkg::idle_st
                     && state != cpu_io_pkg::stop_st) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= cpu_io_pkg::idle_st;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
            io.wbusy <= 1'b0;
            io.wdone <= 1'b0;
        end else begin
            io.wdone <= 1'b0;
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                cpu_io_pkg::idle_st: begin
                    baud_cnt <= '0;
                    if (io.wen) begin
                        tx       <= 1'b0;
                        io.wbusy <= 1'b1;
                        bit_cnt  <= '0;
                        state    <= cpu_io_pkg::start_st;
                    end
                end
                cpu_io_pkg::start_st: begin
                    if (bit_end) begin
                        tx    <= shift[0];
                        state <= cpu_io_pkg::data_st;
                    end
                end
                cpu_io_pkg::data_st: begin
                    if (bit_end) begin
                        if (bit_cnt == cpu_io_pkg::bit_last) begin
                            tx    <= 1'b1;
                            state <= cpu_io_pkg::stop_st;
                        end else begin
                            tx      <= shift[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // end of stop bit
                    if (bit_end) begin
                        io.wbusy <= 1'b0;
                        io.wdone <= 1'b1;
                        state    <= cpu_io_pkg::idle_st;
                    end
                end
            endcase
        end
    end

    a_no_wen_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        io.wen |-> !io.wbusy
    );

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

module uart_rx (
    input  wire logic clk,
    input  wire logic rstn,
    uart_rx_if.rx     io,
    input  wire logic rx
);

    cpu_io_pkg::uart_state_t           state;
    logic [cpu_io_pkg::baud_w-1:0]     baud_cnt;
    logic [cpu_io_pkg::bit_cnt_w-1:0]  bit_cnt;
    logic [cpu_io_pkg::byte_w-1:0]     shift;
    logic [cpu_io_pkg::byte_w-1:0]     buf_q;
    logic                              full;
    logic                              req;
    logic                              rx_meta;
    logic                              rx_s;
    logic                              fill;
    logic                              hand;

    // two flop synchronizer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    // mid stop bit
    assign fill = (state == cpu_io_pkg::stop_st) && (baud_cnt == cpu_io_pkg::baud_last);
    assign hand = (io.ren || req) && full;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= cpu_io_pkg::idle_st;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                cpu_io_pkg::idle_st: begin
                    baud_cnt <= '0;
                    if (!rx_s) begin
                        state <= cpu_io_pkg::start_st;
                    end
                end
                cpu_io_pkg::start_st: begin
                    if (baud_cnt == cpu_io_pkg::baud_half) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        // glitch if the line went back high
                        state    <= rx_s ? cpu_io_pkg::idle_st : cpu_io_pkg::data_st;
                    end
                end
                cpu_io_pkg::data_st: begin
                    if (baud_cnt == cpu_io_pkg::baud_last) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == cpu_io_pkg::bit_last) begin
                            state <= cpu_io_pkg::stop_st;
                        end
                    end
                end
                default: begin
                    if (fill) begin
                        state <= cpu_io_pkg::idle_st;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == cpu_io_pkg::data_st && baud_cnt == cpu_io_pkg::baud_last) begin
            shift <= {rx_s, shift[cpu_io_pkg::byte_w-1:1]};
        end
        if (fill) begin
            buf_q <= shift;
        end
    end

    // ==============================
    // holding buffer handshake
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            full     <= 1'b0;
            req      <= 1'b0;
            io.rdone <= 1'b0;
        end else begin
            io.rdone <= hand;
            if (fill) begin
                full <= 1'b1;
            end else if (hand) begin
                full <= 1'b0;
            end
            if (hand) begin
                req <= 1'b0;
            end else if (io.ren) begin
                req <= 1'b1;
            end
        end
    end

    assign io.rdata = buf_q;
    assign io.rbusy = (state != cpu_io_pkg::idle_st);

endmodule

`default_nettype wire

// File: hw/io_sequencer.sv
`default_nettype none

module io_sequencer (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic                              inst_valid,
    output logic                                   inst_ready,
    input  wire cpu_io_pkg::op_t                   inst_op,
    input  wire logic [cpu_io_pkg::reg_addr_w-1:0] inst_rt,
    input  wire logic [cpu_io_pkg::xlen-1:0]       inst_imm,
    uart_tx_if.seq                                 tx_io,
    uart_rx_if.seq                                 rx_io,
    output logic                                   we,
    output logic      [cpu_io_pkg::reg_addr_w-1:0] waddr,
    output logic      [cpu_io_pkg::xlen-1:0]       wdata,
    output logic      [cpu_io_pkg::reg_addr_w-1:0] raddr,
    input  wire logic [cpu_io_pkg::xlen-1:0]       rdata
);

    cpu_io_pkg::io_state_t                 state;
    logic [cpu_io_pkg::reg_addr_w-1:0]     rt_q;
    logic [cpu_io_pkg::byte_w-1:0]         byte_q;
    logic                                  accept;
    logic                                  rd_write;

    assign accept   = inst_valid && inst_ready;
    assign rd_write = (state == cpu_io_pkg::read_st) && rx_io.rdone;

    // ==============================
    // register file steering
    // ==============================
    assign raddr = inst_rt;
    assign we    = (accept && inst_op == cpu_io_pkg::op_li) || rd_write;
    assign waddr = rd_write ? rt_q : inst_rt;
    assign wdata = rd_write ? {{(cpu_io_pkg::xlen - cpu_io_pkg::byte_w){1'b0}}, rx_io.rdata}
                            : inst_imm;

    assign tx_io.wdata = byte_q;

    // target and outgoing byte held for the whole stall
    always_ff @(posedge clk) begin
        if (accept && (inst_op == cpu_io_pkg::op_inll || inst_op == cpu_io_pkg::op_outll)) begin
            rt_q   <= inst_rt;
            byte_q <= rdata[cpu_io_pkg::byte_w-1:0];
        end
    end

    // ==============================
    // interlock fsm
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= cpu_io_pkg::run_st;
            inst_ready  <= 1'b1;
            tx_io.wen   <= 1'b0;
            rx_io.ren   <= 1'b0;
        end else begin
            case (state)
                cpu_io_pkg::run_st: begin
                    if (accept && inst_op == cpu_io_pkg::op_inll) begin
                        inst_ready <= 1'b0;
                        state      <= cpu_io_pkg::pre_read_st;
                    end else if (accept && inst_op == cpu_io_pkg::op_outll) begin
                        inst_ready <= 1'b0;
                        state      <= cpu_io_pkg::pre_write_st;
                    end
                end
                cpu_io_pkg::pre_read_st: begin
                    if (!rx_io.rbusy) begin
                        rx_io.ren <= 1'b1;
                        state     <= cpu_io_pkg::read_st;
                    end
                end
                cpu_io_pkg::read_st: begin
                    rx_io.ren <= 1'b0;
                    if (rx_io.rdone) begin
                        inst_ready <= 1'b1;
                        state      <= cpu_io_pkg::run_st;
                    end
                end
                cpu_io_pkg::pre_write_st: begin
                    if (!tx_io.wbusy) begin
                        tx_io.wen <= 1'b1;
                        state     <= cpu_io_pkg::write_st;
                    end
                end
                default: begin
                    tx_io.wen <= 1'b0;
                    // frame fully out
                    if (tx_io.wdone) begin
                        inst_ready <= 1'b1;
                        state      <= cpu_io_pkg::run_st;
                    end
                end
            endcase
        end
    end

    // stream also held while the transmitter is busy
    a_stall_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        (state != cpu_io_pkg::run_st || tx_io.wbusy) |-> !inst_ready
    );

endmodule

`default_nettype wire

// File: hw/cpu_io_top.sv
`default_nettype none

module cpu_io_top (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic                              inst_valid,
    output logic                                   inst_ready,
    input  wire cpu_io_pkg::op_t                   inst_op,
    input  wire logic [cpu_io_pkg::reg_addr_w-1:0] inst_rt,
    input  wire logic [cpu_io_pkg::xlen-1:0]       inst_imm,
    input  wire logic                              rx,
    output logic                                   tx,
    output logic      [cpu_io_pkg::byte_w-1:0]     led
);

    logic                              rf_we;
    logic [cpu_io_pkg::reg_addr_w-1:0] rf_waddr;
    logic [cpu_io_pkg::xlen-1:0]       rf_wdata;
    logic [cpu_io_pkg::reg_addr_w-1:0] rf_raddr;
    logic [cpu_io_pkg::xlen-1:0]       rf_rdata;

    uart_tx_if tx_bus ();
    uart_rx_if rx_bus ();

    io_sequencer u_seq (
        .clk        (clk),
        .rstn       (rstn),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_op    (inst_op),
        .inst_rt    (inst_rt),
        .inst_imm   (inst_imm),
        .tx_io      (tx_bus.seq),
        .rx_io      (rx_bus.seq),
        .we         (rf_we),
        .waddr      (rf_waddr),
        .wdata      (rf_wdata),
        .raddr      (rf_raddr),
        .rdata      (rf_rdata)
    );

    reg_file u_rf (
        .clk   (clk),
        .rstn  (rstn),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .led   (led)
    );

    // ==============================
    // serial engines
    // ==============================
    uart_tx u_tx (
        .clk  (clk),
        .rstn (rstn),
        .io   (tx_bus.tx),
        .tx   (tx)
    );

    uart_rx u_rx (
        .clk  (clk),
        .rstn (rstn),
        .io   (rx_bus.rx),
        .rx   (rx)
    );

endmodule

`default_nettype wire

// File: bench/tb_cpu_io.sv
`default_nettype none

module tb_cpu_io;

    localparam int bit_cycles = cpu_io_pkg::clks_per_bit;
    localparam int wait_limit = 40 * cpu_io_pkg::clks_per_bit;

    logic                              clk;
    logic                              rstn;
    logic                              inst_valid;
    logic                              inst_ready;
    cpu_io_pkg::op_t                   inst_op;
    logic [cpu_io_pkg::reg_addr_w-1:0] inst_rt;
    logic [cpu_io_pkg::xlen-1:0]       inst_imm;
    logic                              rx;
    logic                              tx;
    logic [cpu_io_pkg::byte_w-1:0]     led;

    // expected register contents
    logic [cpu_io_pkg::xlen-1:0] shadow [cpu_io_pkg::num_regs];
    logic [31:0]                 rng;
    int                          errors;
    int                          timeouts;

    cpu_io_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_op    (inst_op),
        .inst_rt    (inst_rt),
        .inst_imm   (inst_imm),
        .rx         (rx),
        .tx         (tx),
        .led        (led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // concurrent checks
    // ==============================
    // no frame on tx unless the stream is stalled
    tx_idle_when_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        inst_ready |-> tx
    ) else begin
        errors++;
        $display("FAILED tx=%h while inst_ready=%h", $sampled(tx), $sampled(inst_ready));
    end

    // held instructions must not reach r0 during a stall
    led_frozen_in_stall: assert property (
        @(posedge clk) disable iff (!rstn)
        (!inst_ready && !$past(inst_ready)) |-> $stable(led)
    ) else begin
        errors++;
        $display("FAILED led=%h changed during stall, was %h", $sampled(led), $past(led));
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!inst_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!inst_ready) begin
            timeouts++;
            $display("timeout while waiting for inst_ready to return high");
        end
    endtask

    // present at a falling edge, return at the falling edge after acceptance
    task automatic issue(input cpu_io_pkg::op_t op,
                         input logic [cpu_io_pkg::reg_addr_w-1:0] rt,
                         input logic [cpu_io_pkg::xlen-1:0] imm);
        inst_valid = 1'b1;
        inst_op    = op;
        inst_rt    = rt;
        inst_imm   = imm;
        wait_ready();
        @(posedge clk);
        if (op == cpu_io_pkg::op_li) begin
            shadow[rt] = imm;
        end
        @(negedge clk);
        inst_valid = 1'b0;
        inst_op    = cpu_io_pkg::op_nop;
    endtask

    // ==============================
    // serial line models
    // ==============================
    task automatic send_frame(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
    endtask

    task automatic decode_frame(output logic [7:0] b);
        int n;
        n = 0;
        b = '0;
        while (tx && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (tx) begin
            timeouts++;
            $display("timeout while waiting for a start bit on tx");
        end else begin
            // to mid start bit, then one bit period per sample
            repeat (bit_cycles / 2) @(negedge clk);
            check_eq("tx start bit", 32'(tx), 32'h0);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_cycles) @(negedge clk);
                b[i] = tx;
            end
            repeat (bit_cycles) @(negedge clk);
            check_eq("tx stop bit", 32'(tx), 32'h1);
            check_eq("inst_ready in stop bit", 32'(inst_ready), 32'h0);
        end
    endtask

    task automatic run_outll(input logic [cpu_io_pkg::reg_addr_w-1:0] rt);
        logic [7:0] got;
        issue(cpu_io_pkg::op_outll, rt, '0);
        decode_frame(got);
        check_eq("tx byte", 32'(got), 32'(shadow[rt][7:0]));
        wait_ready();
    endtask

    task automatic run_inll(input logic [cpu_io_pkg::reg_addr_w-1:0] rt, input logic [7:0] b);
        issue(cpu_io_pkg::op_inll, rt, '0);
        check_eq("inst_ready before rx frame", 32'(inst_ready), 32'h0);
        send_frame(b);
        wait_ready();
        shadow[rt] = {24'b0, b};
    endtask

    initial begin
        logic [31:0] val;
        logic [7:0]  b;
        rng        = 32'ha228_741f;
        errors     = 0;
        timeouts   = 0;
        rstn       = 1'b0;
        inst_valid = 1'b0;
        inst_op    = cpu_io_pkg::op_nop;
        inst_rt    = '0;
        inst_imm   = '0;
        rx         = 1'b1;
        for (int i = 0; i < cpu_io_pkg::num_regs; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // after reset
        check_eq("inst_ready", 32'(inst_ready), 32'h1);
        check_eq("tx", 32'(tx), 32'h1);
        check_eq("led", 32'(led), 32'h0);

        // ==============================
        // load immediate and led tap
        // ==============================
        val = next_rand();
        issue(cpu_io_pkg::op_li, 5'd0, val);
        check_eq("led", 32'(led), 32'(val[7:0]));
        for (int i = 1; i < 6; i++) begin
            issue(cpu_io_pkg::op_li, 5'(i * 5), next_rand());
            check_eq("led", 32'(led), 32'(shadow[0][7:0]));
        end
        issue(cpu_io_pkg::op_nop, 5'd0, next_rand());
        check_eq("led", 32'(led), 32'(shadow[0][7:0]));
        check_eq("inst_ready", 32'(inst_ready), 32'h1);

        // serial output of loaded registers
        run_outll(5'd10);
        run_outll(5'd0);

        // ==============================
        // serial input and echo
        // ==============================
        val = next_rand();
        b   = val[7:0];
        run_inll(5'd0, b);
        check_eq("led", 32'(led), 32'(b));
        val = next_rand();
        run_inll(5'd9, val[7:0]);
        run_outll(5'd9);
        run_outll(5'd0);

        // li held behind an outll
        issue(cpu_io_pkg::op_outll, 5'd20, '0);
        val = next_rand();
        fork
            issue(cpu_io_pkg::op_li, 5'd0, val);
            begin
                decode_frame(b);
                check_eq("tx byte", 32'(b), 32'(shadow[20][7:0]));
            end
        join
        check_eq("led", 32'(led), 32'(val[7:0]));
        run_outll(5'd0);

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/cpu_io_pkg.sv
hw/io_if.sv
hw/reg_file.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/io_sequencer.sv
hw/cpu_io_top.sv
bench/tb_cpu_io.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_cpu_io
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
